// File: design/a78_settings.svh
// Width, depth, header offset, status bit and aspect constants
// for the 7800 platform glue
`ifndef A78_SETTINGS_SVH
`define A78_SETTINGS_SVH

// ==============================
// Widths and depths
// ==============================
`define A78_DL_ADDR_BITS     25
// 16 KiB of cartridge ROM
`define A78_ROM_ADDR_BITS    14
`define A78_HDR_LEN          128
// Download index of a cartridge image
`define A78_CART_INDEX       1
`define A78_HDR_SIZE_DEFAULT 32'h8000

// Byte offsets inside the 7800 header
`define A78_OFS_MAGIC_FIRST  1
`define A78_OFS_SIZE_FIRST   49
`define A78_OFS_FLAGS_FIRST  53
`define A78_OFS_REGION       57
`define A78_OFS_SAVE         58
`define A78_OFS_XM           63

// ==============================
// Status word bit positions
// ==============================
`define A78_ST_RESET         0
`define A78_ST_SWAP          7
`define A78_ST_ASPECT        8
// Three scale bits start here
`define A78_ST_SCALE_LO      9
`define A78_ST_DIFF_R        12
`define A78_ST_DIFF_L        13
// Two region bits and two high score bits
`define A78_ST_REGION_LO     15
`define A78_ST_HSC_LO        18

// Aspect pairs for the scaler
`define A78_AR_WIDE_X        16
`define A78_AR_WIDE_Y        9
`define A78_AR_ORIG_X        1535
`define A78_AR_ORIG_Y        1294

`endif

// File: design/a78_pkg.sv
// Shared vector typedefs and packed structs
// for the download stream and cartridge info
`default_nettype none
`include "a78_settings.svh"

package a78_pkg;

	// Plain vectors with a meaning
	typedef logic [7:0]                      byte_t;
	typedef logic [`A78_DL_ADDR_BITS-1:0]    dl_addr_t;
	typedef logic [`A78_ROM_ADDR_BITS-1:0]   rom_addr_t;
	typedef logic [31:0]                     cart_size_t;
	typedef logic [15:0]                     cart_flags_t;

	// Host joystick word, all bits active high
	// 0 right, 1 left, 2 down, 3 up, 4 fire1, 5 fire2
	// 6 pause, 7 select, 8 start, 9 paddle up, 10 paddle down
	typedef logic [15:0]                     joy_t;

	// Host option word
	typedef logic [31:0]                     status_t;

	// One beat of the host download stream
	typedef struct packed {
		logic     active;
		byte_t    index;
		dl_addr_t addr;
		byte_t    data;
		logic     wr;
	} dl_beat_t;

	// Fields pulled out of the 7800 header
	typedef struct packed {
		logic        is_7800;
		// 0 NTSC, 1 PAL
		byte_t       region;
		// 0 none, 1 high score cart, 2 savekey
		byte_t       save_type;
		byte_t       xm;
		cart_flags_t flags;
		cart_size_t  size;
	} cart_info_t;

endpackage

`default_nettype wire

// File: design/a78_cart_loader.sv
// Download stream parser for the 7800 header
// Header fields, image size and ROM write port
`default_nettype none
`include "a78_settings.svh"

module a78_cart_loader (
	input  wire                  CLK_VIDEO,
	input  wire                  rst_n,
	input  wire a78_pkg::dl_beat_t dl,
	output a78_pkg::cart_info_t  info,
	output logic                 rom_we,
	output a78_pkg::rom_addr_t   rom_waddr,
	output a78_pkg::byte_t       rom_wdata,
	output logic                 cart_load
);

	localparam logic [39:0] MAGIC      = "ATARI";
	// Last offset of each multi-byte field
	localparam int          MAGIC_LAST = `A78_OFS_MAGIC_FIRST + 4;
	localparam int          SIZE_LAST  = `A78_OFS_SIZE_FIRST + 3;
	localparam int          FLAGS_LAST = `A78_OFS_FLAGS_FIRST + 1;

	logic                 cart_dl;
	logic                 hdr_wr;
	logic                 cart_dl_q;
	logic [39:0]          magic;
	logic                 is_7800;
	a78_pkg::cart_size_t  hdr_size;
	a78_pkg::cart_size_t  raw_size;
	a78_pkg::cart_size_t  size_q;
	a78_pkg::cart_flags_t flags;
	a78_pkg::byte_t       region;
	a78_pkg::byte_t       save_type;
	a78_pkg::byte_t       xm;
	a78_pkg::dl_addr_t    last_addr;
	a78_pkg::dl_addr_t    wr_addr;

	// Cartridge images use download index 1
	assign cart_dl = dl.active && (dl.index[5:0] == 6'(`A78_CART_INDEX));
	assign hdr_wr  = cart_dl && dl.wr;

	// ==============================
	// Header capture
	// ==============================
	// Bytes come in rising order, so shift each field in MSB first
	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			magic     <= MAGIC;
			hdr_size  <= `A78_HDR_SIZE_DEFAULT;
			flags     <= '0;
			region    <= '0;
			save_type <= '0;
			xm        <= '0;
		end else if (hdr_wr) begin
			if (dl.addr >= `A78_OFS_MAGIC_FIRST && dl.addr <= MAGIC_LAST)
				magic <= {magic[31:0], dl.data};
			if (dl.addr >= `A78_OFS_SIZE_FIRST && dl.addr <= SIZE_LAST)
				hdr_size <= {hdr_size[23:0], dl.data};
			if (dl.addr >= `A78_OFS_FLAGS_FIRST && dl.addr <= FLAGS_LAST)
				flags <= {flags[7:0], dl.data};
			if (dl.addr == `A78_OFS_REGION)
				region <= dl.data;
			if (dl.addr == `A78_OFS_SAVE)
				save_type <= dl.data;
			if (dl.addr == `A78_OFS_XM)
				xm <= dl.data;
		end
	end

	// Image size from the last written address
	assign raw_size = a78_pkg::cart_size_t'(last_addr) + 32'd1;

	// Magic compare, end of download and final size
	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			is_7800   <= 1'b0;
			cart_dl_q <= 1'b0;
			last_addr <= '0;
			size_q    <= `A78_HDR_SIZE_DEFAULT;
		end else begin
			is_7800   <= (magic == MAGIC);
			cart_dl_q <= cart_dl;
			if (hdr_wr)
				last_addr <= dl.addr;
			// Falling edge of the cartridge download
			if (cart_dl_q && !cart_dl)
				size_q <= is_7800 ? hdr_size : raw_size;
		end
	end

	// ==============================
	// ROM write port
	// ==============================
	// Strip the 128 byte header from 7800 images
	assign wr_addr = (is_7800 && dl.addr >= `A78_HDR_LEN) ?
		dl.addr - a78_pkg::dl_addr_t'(`A78_HDR_LEN) : dl.addr;

	assign rom_we    = hdr_wr;
	assign rom_waddr = wr_addr[`A78_ROM_ADDR_BITS-1:0];
	assign rom_wdata = dl.data;
	assign cart_load = cart_dl;

	always_comb begin
		info.is_7800   = is_7800;
		info.region    = region;
		info.save_type = save_type;
		info.xm        = xm;
		// Flags only mean something for 7800 images
		info.flags     = is_7800 ? flags : '0;
		info.size      = size_q;
	end

endmodule

`default_nettype wire

// File: design/a78_cart_rom.sv
// On-chip cartridge ROM with a single shared port
`default_nettype none
`include "a78_settings.svh"

module a78_cart_rom (
	input  wire                       CLK_VIDEO,
	input  wire                       cart_load,
	input  wire                       rom_we,
	input  wire a78_pkg::rom_addr_t   rom_waddr,
	input  wire a78_pkg::byte_t       rom_wdata,
	input  wire a78_pkg::rom_addr_t   cart_addr,
	output a78_pkg::byte_t            cart_data
);

	localparam int DEPTH = 2 ** `A78_ROM_ADDR_BITS;

	a78_pkg::byte_t     mem [0:DEPTH-1];
	a78_pkg::rom_addr_t port_addr;

	// Download owns the port while loading
	assign port_addr = cart_load ? rom_waddr : cart_addr;

	// Registered read, data one cycle after the address
	always_ff @(posedge CLK_VIDEO) begin
		if (cart_load && rom_we)
			mem[port_addr] <= rom_wdata;
		cart_data <= mem[port_addr];
	end

endmodule

`default_nettype wire

// File: design/a78_input_map.sv
// Joystick swap and mapping onto RIOT ports and TIA inputs
`default_nettype none
`include "a78_settings.svh"

module a78_input_map (
	input  wire a78_pkg::status_t status,
	input  wire a78_pkg::joy_t    joy0,
	input  wire a78_pkg::joy_t    joy1,
	input  wire a78_pkg::byte_t   pb_out,
	input  wire                   tia_en,
	output a78_pkg::byte_t        pa_in,
	output a78_pkg::byte_t        pb_in,
	output logic [1:0]            ilatch,
	output logic [3:0]            idump
);

	// Joystick word bit positions
	localparam int J_RIGHT  = 0;
	localparam int J_LEFT   = 1;
	localparam int J_DOWN   = 2;
	localparam int J_UP     = 3;
	localparam int J_FIRE1  = 4;
	localparam int J_FIRE2  = 5;
	localparam int J_PAUSE  = 6;
	localparam int J_SELECT = 7;
	localparam int J_START  = 8;
	localparam int J_PAD_UP = 9;
	localparam int J_PAD_DN = 10;

	a78_pkg::joy_t joya;
	a78_pkg::joy_t joyb;
	logic          joya_b2;
	logic          joyb_b2;

	// Optional player swap
	assign joya = status[`A78_ST_SWAP] ? joy1 : joy0;
	assign joyb = status[`A78_ST_SWAP] ? joy0 : joy1;

	// Directions, active low, R L D U per nibble
	assign pa_in[7:4] = ~{joya[J_RIGHT], joya[J_LEFT], joya[J_DOWN], joya[J_UP]};
	assign pa_in[3:0] = ~{joyb[J_RIGHT], joyb[J_LEFT], joyb[J_DOWN], joyb[J_UP]};

	// Console switches on port B
	assign pb_in[7] = status[`A78_ST_DIFF_R];
	assign pb_in[6] = status[`A78_ST_DIFF_L];
	assign pb_in[5] = 1'b1;
	assign pb_in[4] = 1'b1;
	assign pb_in[3] = ~(joya[J_PAUSE] | joyb[J_PAUSE]);
	assign pb_in[2] = 1'b1;
	assign pb_in[1] = ~(joya[J_SELECT] | joyb[J_SELECT]);
	assign pb_in[0] = ~(joya[J_START] | joyb[J_START]);

	// Either fire button pulls the latch low
	assign ilatch[0] = ~(joya[J_FIRE1] | joya[J_FIRE2]);
	assign ilatch[1] = ~(joyb[J_FIRE1] | joyb[J_FIRE2]);

	// Console drives PB2 / PB4 low to select two button mode
	assign joya_b2 = ~tia_en & ~pb_out[2];
	assign joyb_b2 = ~tia_en & ~pb_out[4];

	// Dump pairs in B0 B1 A0 A1 order
	assign idump[3] = joyb_b2 ? joyb[J_FIRE1] : joyb[J_PAD_UP];
	assign idump[2] = joyb_b2 ? joyb[J_FIRE2] : joyb[J_PAD_DN];
	assign idump[1] = joya_b2 ? joya[J_FIRE1] : joya[J_PAD_UP];
	assign idump[0] = joya_b2 ? joya[J_FIRE2] : joya[J_PAD_DN];

endmodule

`default_nettype wire

// File: design/a78_video_ctrl.sv
// Pixel enable divider, scaler and aspect option decoding
`default_nettype none
`include "a78_settings.svh"

module a78_video_ctrl (
	input  wire                   CLK_VIDEO,
	input  wire                   rst_n,
	input  wire a78_pkg::status_t status,
	input  wire                   forced_scandoubler,
	output logic                  ce_pix,
	output logic [1:0]            vga_sl,
	output logic                  scandoubler,
	output logic                  hq2x,
	output logic [12:0]           video_arx,
	output logic [12:0]           video_ary
);

	logic [2:0] div;
	logic [2:0] scale;
	logic [2:0] sl;

	// ==============================
	// Pixel enable
	// ==============================
	// One pulse every 8 clocks
	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			div    <= '0;
			ce_pix <= 1'b0;
		end else begin
			div    <= div + 3'd1;
			ce_pix <= (div == 3'd0);
		end
	end

	// Scale option, 0 none, 1 HQ2x, then CRT levels
	assign scale       = status[`A78_ST_SCALE_LO +: 3];
	assign sl          = (scale != 3'd0) ? scale - 3'd1 : 3'd0;
	assign vga_sl      = sl[1:0];
	assign scandoubler = (scale != 3'd0) || forced_scandoubler;
	assign hq2x        = (scale == 3'd1);

	// Wide screen or original pixel aspect
	assign video_arx = status[`A78_ST_ASPECT] ? 13'(`A78_AR_WIDE_X) : 13'(`A78_AR_ORIG_X);
	assign video_ary = status[`A78_ST_ASPECT] ? 13'(`A78_AR_WIDE_Y) : 13'(`A78_AR_ORIG_Y);

endmodule

`default_nettype wire

// File: design/a78_config_decode.sv
// Console reset, region, high score cart and TIA mode selection
`default_nettype none
`include "a78_settings.svh"

module a78_config_decode (
	input  wire                      CLK_VIDEO,
	input  wire                      rst_n,
	input  wire a78_pkg::status_t    status,
	input  wire                      dl_active,
	input  wire a78_pkg::cart_info_t info,
	output logic                     console_reset,
	output logic                     region_pal,
	output logic                     hsc_en,
	output logic                     tia_mode
);

	logic [1:0] region_opt;
	logic [1:0] hsc_opt;

	// Hold the console in reset during any download
	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n)
			console_reset <= 1'b1;
		else
			console_reset <= status[`A78_ST_RESET] | dl_active;
	end

	// Region option, 0 auto, 1 NTSC, 2 PAL
	assign region_opt = status[`A78_ST_REGION_LO +: 2];
	assign region_pal = (region_opt == 2'b00) ? info.region[0] : region_opt[1];

	// High score cart, 0 auto, 1 on, 2 off
	assign hsc_opt = status[`A78_ST_HSC_LO +: 2];

	// Auto enables it for carts with a save type or XM
	always_comb begin
		if (hsc_opt == 2'b00)
			hsc_en = (info.save_type != 8'd0) || info.xm[0];
		else
			hsc_en = hsc_opt[0];
	end

	// Images without the magic run as 2600 carts
	assign tia_mode = ~info.is_7800;

endmodule

`default_nettype wire

// File: design/a78_platform_top.sv
// Top level of the 7800 board glue
// Loader, cart ROM, input map, video and config decode
`default_nettype none

module a78_platform_top (
	input  wire                       CLK_VIDEO,
	input  wire                       rst_n,

	// Host side
	input  wire a78_pkg::dl_beat_t    dl,
	input  wire a78_pkg::status_t     status,
	input  wire a78_pkg::joy_t        joy0,
	input  wire a78_pkg::joy_t        joy1,
	input  wire                       forced_scandoubler,

	// From the console core
	input  wire a78_pkg::rom_addr_t   cart_addr,
	input  wire a78_pkg::byte_t       pb_out,
	input  wire                       tia_en,

	// Cartridge
	output a78_pkg::cart_info_t       info,
	output a78_pkg::byte_t            cart_data,

	// Controllers
	output a78_pkg::byte_t            pa_in,
	output a78_pkg::byte_t            pb_in,
	output logic [1:0]                ilatch,
	output logic [3:0]                idump,

	// Video
	output logic                      ce_pix,
	output logic [1:0]                vga_sl,
	output logic                      scandoubler,
	output logic                      hq2x,
	output logic [12:0]               video_arx,
	output logic [12:0]               video_ary,

	// Console configuration
	output logic                      console_reset,
	output logic                      region_pal,
	output logic                      hsc_en,
	output logic                      tia_mode
);

	// Loader to ROM write port
	logic               rom_we;
	a78_pkg::rom_addr_t rom_waddr;
	a78_pkg::byte_t     rom_wdata;
	logic               cart_load;

	a78_cart_loader a78_cart_loader_inst (
		.CLK_VIDEO (CLK_VIDEO),
		.rst_n     (rst_n),
		.dl        (dl),
		.info      (info),
		.rom_we    (rom_we),
		.rom_waddr (rom_waddr),
		.rom_wdata (rom_wdata),
		.cart_load (cart_load)
	);

	a78_cart_rom a78_cart_rom_inst (
		.CLK_VIDEO (CLK_VIDEO),
		.cart_load (cart_load),
		.rom_we    (rom_we),
		.rom_waddr (rom_waddr),
		.rom_wdata (rom_wdata),
		.cart_addr (cart_addr),
		.cart_data (cart_data)
	);

	a78_input_map a78_input_map_inst (
		.status (status),
		.joy0   (joy0),
		.joy1   (joy1),
		.pb_out (pb_out),
		.tia_en (tia_en),
		.pa_in  (pa_in),
		.pb_in  (pb_in),
		.ilatch (ilatch),
		.idump  (idump)
	);

	a78_video_ctrl a78_video_ctrl_inst (
		.CLK_VIDEO          (CLK_VIDEO),
		.rst_n              (rst_n),
		.status             (status),
		.forced_scandoubler (forced_scandoubler),
		.ce_pix             (ce_pix),
		.vga_sl             (vga_sl),
		.scandoubler        (scandoubler),
		.hq2x               (hq2x),
		.video_arx          (video_arx),
		.video_ary          (video_ary)
	);

	// Any download, cart or not, holds the console in reset
	a78_config_decode a78_config_decode_inst (
		.CLK_VIDEO     (CLK_VIDEO),
		.rst_n         (rst_n),
		.status        (status),
		.dl_active     (dl.active),
		.info          (info),
		.console_reset (console_reset),
		.region_pal    (region_pal),
		.hsc_en        (hsc_en),
		.tia_mode      (tia_mode)
	);

endmodule

`default_nettype wire

// File: verif/a78_tb_clock.sv
// Testbench clock and power-on reset
`default_nettype none

module a78_tb_clock (
	output logic CLK_VIDEO,
	output logic rst_n
);

	localparam int HALF_PERIOD  = 5;
	localparam int RESET_CYCLES = 2;

	// Free-running clock, period 10
	initial begin
		CLK_VIDEO = 1'b0;
		forever begin
			#HALF_PERIOD;
			CLK_VIDEO = ~CLK_VIDEO;
		end
	end

	// Reset low for two cycles, released just after an edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK_VIDEO);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/a78_platform_tb.sv
// Testbench for the 7800 board glue
// Downloads, ROM read back, controller map, video and config checks
`default_nettype none
`include "a78_settings.svh"

module a78_platform_tb;

	// ==============================
	// Run length and watchdog
	// ==============================
	localparam int LEN_7800   = 640;
	localparam int LEN_RAW    = 300;
	localparam int READS      = 64;
	localparam int MAP_CYCLES = 200;
	localparam int PERIOD     = 10;
	// Downloads, reads, config sweeps, mapping, video sweep, slack
	localparam int STIM_CYCLES = LEN_7800 + LEN_RAW + 4 * READS + 2 * 16
		+ MAP_CYCLES + 32 + 20;
	localparam longint WATCHDOG_TIME = 20 * STIM_CYCLES * PERIOD;

	// Header contents of the 7800 image
	localparam logic [39:0] MAGIC_TEXT = "ATARI";
	localparam logic [31:0] HDR_SIZE   = 32'h0000_0200;
	localparam logic [15:0] HDR_FLAGS  = 16'h0123;

	logic                CLK_VIDEO;
	logic                rst_n;
	a78_pkg::dl_beat_t   dl;
	a78_pkg::status_t    status;
	a78_pkg::joy_t       joy0;
	a78_pkg::joy_t       joy1;
	logic                forced_scandoubler;
	a78_pkg::rom_addr_t  cart_addr;
	a78_pkg::byte_t      pb_out;
	logic                tia_en;
	a78_pkg::cart_info_t info;
	a78_pkg::byte_t      cart_data;
	a78_pkg::byte_t      pa_in;
	a78_pkg::byte_t      pb_in;
	logic [1:0]          ilatch;
	logic [3:0]          idump;
	logic                ce_pix;
	logic [1:0]          vga_sl;
	logic                scandoubler;
	logic                hq2x;
	logic [12:0]         video_arx;
	logic [12:0]         video_ary;
	logic                console_reset;
	logic                region_pal;
	logic                hsc_en;
	logic                tia_mode;

	// Image bytes as sent over the download stream
	a78_pkg::byte_t      image [0:1023];
	// Edges seen since reset release
	int                  edge_count = 0;

	a78_tb_clock a78_tb_clock_inst (
		.CLK_VIDEO (CLK_VIDEO),
		.rst_n     (rst_n)
	);

	a78_platform_top a78_platform_top_inst (
		.CLK_VIDEO          (CLK_VIDEO),
		.rst_n              (rst_n),
		.dl                 (dl),
		.status             (status),
		.joy0               (joy0),
		.joy1               (joy1),
		.forced_scandoubler (forced_scandoubler),
		.cart_addr          (cart_addr),
		.pb_out             (pb_out),
		.tia_en             (tia_en),
		.info               (info),
		.cart_data          (cart_data),
		.pa_in              (pa_in),
		.pb_in              (pb_in),
		.ilatch             (ilatch),
		.idump              (idump),
		.ce_pix             (ce_pix),
		.vga_sl             (vga_sl),
		.scandoubler        (scandoubler),
		.hq2x               (hq2x),
		.video_arx          (video_arx),
		.video_ary          (video_ary),
		.console_reset      (console_reset),
		.region_pal         (region_pal),
		.hsc_en             (hsc_en),
		.tia_mode           (tia_mode)
	);

	// ==============================
	// Checking helpers
	// ==============================
	task automatic mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
		$display("ERROR time %0t signal %s expected %0h actual %0h", $time, name, exp, act);
		$display("Simulation failed");
		$fatal(1, "Mismatch on %s", name);
	endtask

	task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (exp === act)
		else mismatch(name, exp, act);
	endtask

	// Player A is the first joystick unless swapped
	function automatic a78_pkg::joy_t pick_player(input logic second, input logic swap,
		input a78_pkg::joy_t j0, input a78_pkg::joy_t j1);
		if (second != swap)
			return j1;
		return j0;
	endfunction

	// Directions inverted, right at the top of each nibble
	function automatic a78_pkg::byte_t expect_pa(input a78_pkg::joy_t a, input a78_pkg::joy_t b);
		a78_pkg::byte_t r;
		for (int i = 0; i < 4; i++) begin
			r[7 - i] = !a[i];
			r[3 - i] = !b[i];
		end
		return r;
	endfunction

	function automatic a78_pkg::byte_t expect_pb(input a78_pkg::status_t st,
		input a78_pkg::joy_t a, input a78_pkg::joy_t b);
		a78_pkg::byte_t r;
		// Unused switch bits read high
		r    = 8'b0011_0100;
		r[7] = st[`A78_ST_DIFF_R];
		r[6] = st[`A78_ST_DIFF_L];
		// Pause, select, start from either player
		r[3] = !(a[6] || b[6]);
		r[1] = !(a[7] || b[7]);
		r[0] = !(a[8] || b[8]);
		return r;
	endfunction

	function automatic logic [3:0] expect_dump(input a78_pkg::joy_t a, input a78_pkg::joy_t b,
		input a78_pkg::byte_t pbo, input logic ten);
		logic [3:0] r;
		// Two button mode swaps paddles for fire buttons
		r[3:2] = (!ten && !pbo[4]) ? {b[4], b[5]} : {b[9], b[10]};
		r[1:0] = (!ten && !pbo[2]) ? {a[4], a[5]} : {a[9], a[10]};
		return r;
	endfunction

	// ==============================
	// Stimulus tasks
	// ==============================
	task automatic fill_image(input int len);
		for (int a = 0; a < len; a++)
			image[a] = 8'($urandom);
	endtask

	// One byte per cycle, then active drops
	task automatic download_image(input int len);
		for (int a = 0; a < len; a++) begin
			@(posedge CLK_VIDEO);
			#1;
			dl.active = 1'b1;
			dl.index  = 8'(`A78_CART_INDEX);
			dl.addr   = a78_pkg::dl_addr_t'(a);
			dl.data   = image[a];
			dl.wr     = 1'b1;
			@(negedge CLK_VIDEO);
			// Console held in reset during the download
			if (a > 0)
				check_eq("console_reset", 1'b1, console_reset);
		end
		@(posedge CLK_VIDEO);
		#1;
		dl.active = 1'b0;
		dl.wr     = 1'b0;
		// Size settles one cycle after active falls
		@(posedge CLK_VIDEO);
		@(negedge CLK_VIDEO);
		check_eq("console_reset", 1'b0, console_reset);
	endtask

	// Random reads, data one cycle after the address
	task automatic read_back(input int span, input int shift);
		int a;
		for (int n = 0; n < READS; n++) begin
			a = $urandom_range(span - 1);
			@(posedge CLK_VIDEO);
			#1;
			cart_addr = a78_pkg::rom_addr_t'(a);
			@(posedge CLK_VIDEO);
			@(negedge CLK_VIDEO);
			check_eq("cart_data", image[a + shift], cart_data);
		end
	endtask

	// Region and high score options, auto picks from the header
	task automatic check_config(input a78_pkg::byte_t region, input a78_pkg::byte_t save,
		input a78_pkg::byte_t xm);
		logic exp_pal;
		logic exp_hsc;
		for (int r = 0; r < 4; r++) begin
			for (int h = 0; h < 4; h++) begin
				@(posedge CLK_VIDEO);
				#1;
				status[`A78_ST_REGION_LO +: 2] = 2'(r);
				status[`A78_ST_HSC_LO +: 2]    = 2'(h);
				@(negedge CLK_VIDEO);
				exp_pal = (r == 0) ? region[0] : r[1];
				exp_hsc = (h == 0) ? ((save != 8'd0) || xm[0]) : h[0];
				check_eq("region_pal", exp_pal, region_pal);
				check_eq("hsc_en", exp_hsc, hsc_en);
			end
		end
		status = '0;
	endtask

	task automatic check_reset_bit();
		@(posedge CLK_VIDEO);
		#1;
		status[`A78_ST_RESET] = 1'b1;
		@(posedge CLK_VIDEO);
		@(negedge CLK_VIDEO);
		check_eq("console_reset", 1'b1, console_reset);
		@(posedge CLK_VIDEO);
		#1;
		status[`A78_ST_RESET] = 1'b0;
		@(posedge CLK_VIDEO);
		@(negedge CLK_VIDEO);
		check_eq("console_reset", 1'b0, console_reset);
	endtask

	task automatic check_mapping();
		a78_pkg::joy_t ja;
		a78_pkg::joy_t jb;
		for (int n = 0; n < MAP_CYCLES; n++) begin
			@(posedge CLK_VIDEO);
			#1;
			joy0   = 16'($urandom);
			joy1   = 16'($urandom);
			status = $urandom;
			pb_out = 8'($urandom);
			tia_en = 1'($urandom);
			@(negedge CLK_VIDEO);
			ja = pick_player(1'b0, status[`A78_ST_SWAP], joy0, joy1);
			jb = pick_player(1'b1, status[`A78_ST_SWAP], joy0, joy1);
			check_eq("pa_in", expect_pa(ja, jb), pa_in);
			check_eq("pb_in", expect_pb(status, ja, jb), pb_in);
			check_eq("ilatch", {!(jb[4] || jb[5]), !(ja[4] || ja[5])}, ilatch);
			check_eq("idump", expect_dump(ja, jb, pb_out, tia_en), idump);
		end
		status = '0;
	endtask

	// Every scale, aspect and forced scandoubler setting
	task automatic check_video();
		logic [2:0] exp_sl;
		for (int s = 0; s < 8; s++) begin
			for (int m = 0; m < 4; m++) begin
				@(posedge CLK_VIDEO);
				#1;
				status = '0;
				status[`A78_ST_SCALE_LO +: 3] = 3'(s);
				status[`A78_ST_ASPECT]        = m[0];
				forced_scandoubler            = m[1];
				@(negedge CLK_VIDEO);
				exp_sl = (s == 0) ? 3'd0 : 3'(s - 1);
				check_eq("vga_sl", exp_sl[1:0], vga_sl);
				check_eq("hq2x", s == 1, hq2x);
				check_eq("scandoubler", (s != 0) || m[1], scandoubler);
				check_eq("video_arx", m[0] ? `A78_AR_WIDE_X : `A78_AR_ORIG_X, video_arx);
				check_eq("video_ary", m[0] ? `A78_AR_WIDE_Y : `A78_AR_ORIG_Y, video_ary);
			end
		end
	endtask

	// ==============================
	// Monitors
	// ==============================
	always @(posedge CLK_VIDEO) begin
		if (rst_n)
			edge_count <= edge_count + 1;
	end

	// Pixel enable on the first edge after release, then every 8th
	always @(negedge CLK_VIDEO) begin
		if (!rst_n) begin
			check_eq("console_reset", 1'b1, console_reset);
			check_eq("ce_pix", 1'b0, ce_pix);
		end else begin
			check_eq("ce_pix", (edge_count % 8) == 1, ce_pix);
		end
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("Simulation failed");
		$fatal(1, "Watchdog timeout");
	end

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		void'($urandom(32'h07422947));
		dl                 = '0;
		status             = '0;
		joy0               = '0;
		joy1               = '0;
		forced_scandoubler = 1'b0;
		cart_addr          = '0;
		pb_out             = 8'hff;
		tia_en             = 1'b1;
		wait (rst_n === 1'b1);
		@(posedge CLK_VIDEO);
		@(negedge CLK_VIDEO);
		// Header fields out of reset
		check_eq("info.is_7800", 1'b1, info.is_7800);
		check_eq("info.size", `A78_HDR_SIZE_DEFAULT, info.size);
		check_eq("info.region", 8'd0, info.region);

		// 7800 image with a full header
		fill_image(LEN_7800);
		for (int i = 0; i < 5; i++)
			image[`A78_OFS_MAGIC_FIRST + i] = MAGIC_TEXT[8 * (4 - i) +: 8];
		for (int i = 0; i < 4; i++)
			image[`A78_OFS_SIZE_FIRST + i] = HDR_SIZE[8 * (3 - i) +: 8];
		image[`A78_OFS_FLAGS_FIRST]     = HDR_FLAGS[15:8];
		image[`A78_OFS_FLAGS_FIRST + 1] = HDR_FLAGS[7:0];
		image[`A78_OFS_REGION]          = 8'd1;
		image[`A78_OFS_SAVE]            = 8'd1;
		image[`A78_OFS_XM]              = 8'h02;
		download_image(LEN_7800);
		check_eq("info.is_7800", 1'b1, info.is_7800);
		check_eq("info.region", 8'd1, info.region);
		check_eq("info.save_type", 8'd1, info.save_type);
		check_eq("info.xm", 8'h02, info.xm);
		check_eq("info.flags", HDR_FLAGS, info.flags);
		check_eq("info.size", HDR_SIZE, info.size);
		check_eq("tia_mode", 1'b0, tia_mode);
		// Body stored with the header stripped
		read_back(LEN_7800 - `A78_HDR_LEN, `A78_HDR_LEN);
		check_config(8'd1, 8'd1, 8'h02);

		// Plain image, no magic
		fill_image(LEN_RAW);
		image[`A78_OFS_MAGIC_FIRST] = 8'h00;
		image[`A78_OFS_REGION]      = 8'd0;
		image[`A78_OFS_SAVE]        = 8'd0;
		image[`A78_OFS_XM]          = 8'h02;
		download_image(LEN_RAW);
		check_eq("info.is_7800", 1'b0, info.is_7800);
		check_eq("info.size", LEN_RAW, info.size);
		check_eq("info.flags", 16'd0, info.flags);
		check_eq("tia_mode", 1'b1, tia_mode);
		read_back(LEN_RAW, 0);
		check_config(8'd0, 8'd0, 8'h02);
		check_reset_bit();

		check_mapping();
		check_video();

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/a78_pkg.sv
design/a78_cart_loader.sv
design/a78_cart_rom.sv
design/a78_input_map.sv
design/a78_video_ctrl.sv
design/a78_config_decode.sv
design/a78_platform_top.sv
verif/a78_tb_clock.sv
verif/a78_platform_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator and run it
# A $fatal in the testbench gives a nonzero exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module a78_platform_tb -o a78_sim &&
./obj_dir/a78_sim || exit 1
